// ==== hw/bitstream_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitstream_builder (
    input  logic                               clk,
    input  logic                               resetn,
    output logic [led_pkg::RAM_ADDR_WIDTH-1:0] rd_addr,
    input  logic [7:0]                         rd_data,
    output logic [led_pkg::LED_BITS-1:0]       bitstream,
    output logic                               bitstream_available,
    input  logic                               bitstream_read
);

    logic [$clog2(led_pkg::FRAME_CYCLES)-1:0]                      frame_cnt;
    logic                                                          frame_tick;
    logic                                                          busy;
    logic [$clog2(led_pkg::LED_COUNT)-1:0]                         led_idx;
    logic [$clog2(led_pkg::STRIPE_COUNT*led_pkg::BYTES_PER_LED)-1:0] byte_idx;
    logic                                                          rd_pending;
    logic                                                          data_valid;
    logic                                                          data_last;
    logic                                                          staged;
    logic [led_pkg::LED_BITS-1:0]                                  staging;
    logic [led_pkg::LED_BITS-1:0]                                  word_next;
    logic                                                          start;
    logic                                                          load_out;

    assign frame_tick = (frame_cnt == led_pkg::FRAME_CYCLES - 1);
    // ticks during a running frame are ignored
    assign start      = frame_tick && !busy;
    // bytes arrive in address order, so strip 0 green ends up on top
    assign word_next  = {staging[led_pkg::LED_BITS-9:0], rd_data};
    // last byte may bypass staging when the output is free
    assign load_out   = !bitstream_available && (staged || data_last);

    // frame timer, free running from reset release
    always_ff @(posedge clk) begin
        if (!resetn) begin
            frame_cnt <= '0;
        end else if (frame_tick) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // read sequencer and output handshake
    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy                <= 1'b0;
            led_idx             <= '0;
            byte_idx            <= '0;
            rd_addr             <= '0;
            rd_pending          <= 1'b0;
            data_valid          <= 1'b0;
            data_last           <= 1'b0;
            staged              <= 1'b0;
            bitstream_available <= 1'b0;
        end else begin
            // ram latency of one cycle
            data_valid <= rd_pending;
            data_last  <= rd_pending &&
                          (byte_idx == led_pkg::STRIPE_COUNT * led_pkg::BYTES_PER_LED - 1);
            if (start) begin
                busy       <= 1'b1;
                led_idx    <= '0;
                byte_idx   <= '0;
                rd_addr    <= '0;
                rd_pending <= 1'b1;
            end else if (rd_pending) begin
                // leds are contiguous in memory, address just counts up
                if (byte_idx == led_pkg::STRIPE_COUNT * led_pkg::BYTES_PER_LED - 1) begin
                    rd_pending <= 1'b0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                    rd_addr  <= rd_addr + 1'b1;
                end
            end else if (load_out) begin
                if (led_idx == led_pkg::LED_COUNT - 1) begin
                    // frame done, wait for next tick
                    busy    <= 1'b0;
                    led_idx <= '0;
                end else begin
                    // read ahead for the next led position
                    led_idx    <= led_idx + 1'b1;
                    byte_idx   <= '0;
                    rd_addr    <= rd_addr + 1'b1;
                    rd_pending <= 1'b1;
                end
            end
            if (load_out) begin
                bitstream_available <= 1'b1;
                staged              <= 1'b0;
            end else begin
                if (bitstream_read) begin
                    bitstream_available <= 1'b0;
                end
                // output still busy, park the word
                if (data_last) begin
                    staged <= 1'b1;
                end
            end
        end
    end

    // staging and output word
    always_ff @(posedge clk) begin
        if (data_valid) begin
            staging <= word_next;
        end
        if (load_out) begin
            bitstream <= staged ? staging : word_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/frame_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_ram (
    input  logic                               clk,
    input  logic                               wr_en,
    input  logic [led_pkg::RAM_ADDR_WIDTH-1:0] wr_addr,
    input  logic [7:0]                         wr_data,
    input  logic [led_pkg::RAM_ADDR_WIDTH-1:0] rd_addr,
    output logic [7:0]                         rd_data
);

    // one byte per colour of every led of every strip
    logic [7:0] mem [0:led_pkg::FRAME_BYTES-1];

    // write from spi side, registered read for the builder
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // data shows up one cycle after the address
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hw/led_pkg.sv ====
`default_nettype none

package led_pkg;

    // strip geometry
    // number of parallel strips driven in lockstep
    localparam int STRIPE_COUNT = 3;
    // leds on each strip
    localparam int LED_COUNT = 2;
    // colour bytes per led, sent green, red, blue
    localparam int BYTES_PER_LED = 3;

    // frame memory sizing
    // one byte per colour, per led, per strip
    localparam int FRAME_BYTES = STRIPE_COUNT * LED_COUNT * BYTES_PER_LED;
    localparam int RAM_ADDR_WIDTH = $clog2(FRAME_BYTES);

    // one bitstream word holds one led position of every strip
    // strip 0 sits in the top 24 bits
    localparam int LED_BITS = STRIPE_COUNT * BYTES_PER_LED * 8;

    // ws2812b pulse timing in clock cycles
    // high time of a 0 bit
    localparam int CYCLES_SHORT = 3;
    // high time of a 1 bit
    localparam int CYCLES_LONG = 6;
    // full bit period, high plus low
    localparam int CYCLES_BIT = CYCLES_SHORT + CYCLES_LONG;

    // refresh period, the idle tail doubles as ws2812b reset
    localparam int FRAME_CYCLES = 1000;

endpackage

`default_nettype wire

// ==== hw/led_strip_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_strip_top (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             spi_clk,
    input  logic                             spi_mosi,
    input  logic                             spi_cs_n,
    output logic [led_pkg::STRIPE_COUNT-1:0] led_data
);

    // frame memory write port
    logic                               wr_en;
    logic [led_pkg::RAM_ADDR_WIDTH-1:0] wr_addr;
    logic [7:0]                         wr_data;
    // frame memory read port
    logic [led_pkg::RAM_ADDR_WIDTH-1:0] rd_addr;
    logic [7:0]                         rd_data;
    // builder to serializer
    logic [led_pkg::LED_BITS-1:0]       bitstream;
    logic                               bitstream_available;
    logic                               bitstream_read;

    spi_byte_receiver u_spi_rx (
        .clk      (clk),
        .resetn   (resetn),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_cs_n (spi_cs_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    frame_ram u_frame_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    bitstream_builder u_builder (
        .clk                 (clk),
        .resetn              (resetn),
        .rd_addr             (rd_addr),
        .rd_data             (rd_data),
        .bitstream           (bitstream),
        .bitstream_available (bitstream_available),
        .bitstream_read      (bitstream_read)
    );

    ws2812b_parallel_out u_ws_out (
        .clk                 (clk),
        .resetn              (resetn),
        .bitstream           (bitstream),
        .bitstream_available (bitstream_available),
        .bitstream_read      (bitstream_read),
        .led_data            (led_data)
    );

endmodule

`default_nettype wire

// ==== hw/spi_byte_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_byte_receiver (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               spi_clk,
    input  logic                               spi_mosi,
    input  logic                               spi_cs_n,
    output logic                               wr_en,
    output logic [led_pkg::RAM_ADDR_WIDTH-1:0] wr_addr,
    output logic [7:0]                         wr_data
);

    // two-flop synchronizers plus one history flop for edge detection
    logic       spi_clk_meta;
    logic       spi_clk_sync;
    logic       spi_clk_prev;
    logic       cs_meta;
    logic       cs_sync;
    logic       cs_prev;
    logic       mosi_meta;
    logic       mosi_sync;
    logic       mosi_q;
    logic       clk_rise;
    logic       clk_rise_q;
    logic       cs_fall;
    logic       cs_rise;
    logic [2:0] bit_cnt;
    logic [7:0] shift_reg;
    logic       byte_done;

    assign clk_rise = spi_clk_sync & ~spi_clk_prev;
    assign cs_fall  = ~cs_sync & cs_prev;
    assign cs_rise  = cs_sync & ~cs_prev;

    // pin synchronizers, idle levels on reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            spi_clk_meta <= 1'b0;
            spi_clk_sync <= 1'b0;
            spi_clk_prev <= 1'b0;
            cs_meta      <= 1'b1;
            cs_sync      <= 1'b1;
            cs_prev      <= 1'b1;
            clk_rise_q   <= 1'b0;
        end else begin
            spi_clk_meta <= spi_clk;
            spi_clk_sync <= spi_clk_meta;
            spi_clk_prev <= spi_clk_sync;
            cs_meta      <= spi_cs_n;
            cs_sync      <= cs_meta;
            cs_prev      <= cs_sync;
            // mode 0 sample point, only inside a chip-select frame
            clk_rise_q   <= clk_rise & ~cs_sync;
        end
    end

    // mosi path, mosi_q lines up with clk_rise_q
    always_ff @(posedge clk) begin
        mosi_meta <= spi_mosi;
        mosi_sync <= mosi_meta;
        mosi_q    <= mosi_sync;
        if (clk_rise_q) begin
            // msb first
            shift_reg <= {shift_reg[6:0], mosi_q};
        end
        if (byte_done) begin
            wr_data <= shift_reg;
        end
    end

    // bit counter and write sequencing
    always_ff @(posedge clk) begin
        if (!resetn) begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
        end else begin
            byte_done <= 1'b0;
            // either cs edge drops any partial byte
            if (cs_fall || cs_rise) begin
                bit_cnt <= '0;
            end else if (clk_rise_q) begin
                bit_cnt   <= bit_cnt + 1'b1;
                byte_done <= (bit_cnt == 3'd7);
            end
            // surplus bytes past the frame are dropped
            wr_en <= byte_done && (wr_addr < led_pkg::FRAME_BYTES);
            // new frame restarts at address 0
            if (cs_fall) begin
                wr_addr <= '0;
            end else if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/ws2812b_parallel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module ws2812b_parallel_out (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic [led_pkg::LED_BITS-1:0]     bitstream,
    input  logic                             bitstream_available,
    output logic                             bitstream_read,
    output logic [led_pkg::STRIPE_COUNT-1:0] led_data
);

    logic [led_pkg::LED_BITS-1:0]                  word_q;
    logic                                          active;
    logic [$clog2(led_pkg::BYTES_PER_LED*8)-1:0]   bit_pos;
    logic [$clog2(led_pkg::CYCLES_BIT)-1:0]        cyc_cnt;
    logic [led_pkg::STRIPE_COUNT-1:0]              cur_bit;
    logic [led_pkg::STRIPE_COUNT-1:0]              pulse_high;
    logic                                          bit_end;
    logic                                          word_end;
    logic                                          take_word;

    assign bit_end   = (cyc_cnt == led_pkg::CYCLES_BIT - 1);
    assign word_end  = active && bit_end && (bit_pos == led_pkg::BYTES_PER_LED * 8 - 1);
    // fetch when idle or seamlessly at the end of the last bit
    assign take_word = bitstream_available && (!active || word_end);

    // the whole word shifts left, so each field's top bit is the current one
    always_comb begin
        for (int s = 0; s < led_pkg::STRIPE_COUNT; s++) begin
            cur_bit[s]    = word_q[led_pkg::LED_BITS - 1 - s * led_pkg::BYTES_PER_LED * 8];
            pulse_high[s] = cur_bit[s] ? (cyc_cnt < led_pkg::CYCLES_LONG)
                                       : (cyc_cnt < led_pkg::CYCLES_SHORT);
        end
    end

    // bit timing and handshake
    always_ff @(posedge clk) begin
        if (!resetn) begin
            active         <= 1'b0;
            bit_pos        <= '0;
            cyc_cnt        <= '0;
            bitstream_read <= 1'b0;
            led_data       <= '0;
        end else begin
            // one cycle strobe per latched word
            bitstream_read <= take_word;
            // registered outputs, all strips switch on the same edge
            led_data       <= active ? pulse_high : '0;
            if (take_word) begin
                active  <= 1'b1;
                bit_pos <= '0;
                cyc_cnt <= '0;
            end else if (word_end) begin
                // nothing queued, line idles low
                active  <= 1'b0;
                cyc_cnt <= '0;
            end else if (active) begin
                if (bit_end) begin
                    cyc_cnt <= '0;
                    bit_pos <= bit_pos + 1'b1;
                end else begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                end
            end
        end
    end

    // word register
    always_ff @(posedge clk) begin
        if (take_word) begin
            word_q <= bitstream;
        end else if (active && bit_end) begin
            word_q <= word_q << 1;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the led strip testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_led_strip_top \
    -Mdir obj_dir \
    -f verilog.f

./obj_dir/Vtb_led_strip_top | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== verif/tb_led_strip_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_led_strip_top;

    // bits per strip in one frame, green red blue for each led
    localparam int FRAME_BITS = led_pkg::LED_COUNT * led_pkg::BYTES_PER_LED * 8;
    localparam int RESET_CYCLES = 8;
    // spi_clk half period in clk cycles
    localparam int SPI_HALF = 4;
    // enough bytes that an unsaturated write address would wrap back to 0
    localparam int LONG_FRAME_BYTES = 2 ** led_pkg::RAM_ADDR_WIDTH + 2;
    // full frame, lone partial byte, then the long frame plus a partial byte
    localparam int SPI_BITS = 8 * led_pkg::FRAME_BYTES + 5 + 8 * LONG_FRAME_BYTES + 5;
    // three chip-select frames with setup, hold and spacing
    localparam int SPI_CYCLES = SPI_BITS * 2 * SPI_HALF + 3 * 4 * SPI_HALF;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 6 * led_pkg::FRAME_CYCLES + SPI_CYCLES;

    logic                             clk;
    logic                             resetn;
    logic                             spi_clk;
    logic                             spi_mosi;
    logic                             spi_cs_n;
    logic [led_pkg::STRIPE_COUNT-1:0] led_data;

    // bytes the frame memory should hold
    logic [7:0]                       ref_mem [led_pkg::FRAME_BYTES];
    int                               cycle_count;
    logic                             check_en;
    int                               timing_errors;
    int                               data_errors;
    int                               frames_checked;

    // decoder state, one entry per strip
    logic [led_pkg::STRIPE_COUNT-1:0] prev_level;
    int                               high_cnt [led_pkg::STRIPE_COUNT];
    int                               since_rise [led_pkg::STRIPE_COUNT];
    int                               bit_cnt [led_pkg::STRIPE_COUNT];
    logic [FRAME_BITS-1:0]            shift_bits [led_pkg::STRIPE_COUNT];
    logic [FRAME_BITS-1:0]            frame_bits [led_pkg::STRIPE_COUNT];
    int                               strips_done;
    int                               frames_done;
    int                               last_start;
    logic                             start_known;

    led_strip_top UUT (
        .clk      (clk),
        .resetn   (resetn),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_cs_n (spi_cs_n),
        .led_data (led_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // lines stay low through reset and up to the first frame tick
    assert property (@(posedge clk)
        (cycle_count >= 1 && cycle_count < RESET_CYCLES + led_pkg::FRAME_CYCLES)
        |-> (led_data == '0))
    else begin
        timing_errors++;
        $display("error %0t ns: led_data expected %0h actual %0h", $time, 0, $sampled(led_data));
    end

    // rising edges either on no strip or on every strip
    assert property (@(posedge clk) disable iff (!check_en)
        ((led_data & ~$past(led_data)) == '0) || ((led_data & ~$past(led_data)) == '1))
    else begin
        timing_errors++;
        $display("error %0t ns: led_data rise vector expected all or none actual %b",
                 $time, $sampled(led_data) & ~$past(led_data));
    end

    // advance n clock edges, then drive 1 ns later
    task automatic step_clocks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // mode 0, msb first, data set up half a period before the rising edge
    task automatic spi_shift(input logic [7:0] value, input int nbits);
        for (int i = 7; i > 7 - nbits; i--) begin
            spi_mosi = value[i];
            step_clocks(SPI_HALF);
            spi_clk = 1'b1;
            step_clocks(SPI_HALF);
            spi_clk = 1'b0;
        end
    endtask

    // one chip-select frame of random bytes, optionally cut short by a partial byte
    task automatic send_frame(input int nbytes, input int partial_bits);
        logic [31:0] rnd;
        spi_cs_n = 1'b0;
        step_clocks(SPI_HALF);
        for (int i = 0; i < nbytes; i++) begin
            rnd = $urandom;
            // only the first 18 bytes land in memory
            if (i < led_pkg::FRAME_BYTES) begin
                ref_mem[i] = rnd[7:0];
            end
            spi_shift(rnd[7:0], 8);
        end
        if (partial_bits > 0) begin
            rnd = $urandom;
            spi_shift(rnd[7:0], partial_bits);
        end
        step_clocks(SPI_HALF);
        spi_cs_n = 1'b1;
        step_clocks(2 * SPI_HALF);
    endtask

    // strip s sees led 0 then led 1, each green red blue
    function automatic logic [FRAME_BITS-1:0] expected_bits(input int s);
        logic [FRAME_BITS-1:0] bits;
        bits = '0;
        for (int l = 0; l < led_pkg::LED_COUNT; l++) begin
            for (int c = 0; c < led_pkg::BYTES_PER_LED; c++) begin
                bits = {bits[FRAME_BITS-9:0],
                        ref_mem[(l * led_pkg::STRIPE_COUNT + s) * led_pkg::BYTES_PER_LED + c]};
            end
        end
        return bits;
    endfunction

    // idle tail between frames, long low run on every strip
    task automatic wait_frame_gap();
        int low_run;
        low_run = 0;
        while (low_run < 2 * led_pkg::CYCLES_BIT) begin
            @(negedge clk);
            if (led_data === '0) begin
                low_run++;
            end else begin
                low_run = 0;
            end
        end
        step_clocks(1);
    endtask

    task automatic check_next_frame();
        int                    snap;
        logic [FRAME_BITS-1:0] exp;
        snap = frames_done;
        while (frames_done == snap) begin
            @(posedge clk);
        end
        #1;
        for (int s = 0; s < led_pkg::STRIPE_COUNT; s++) begin
            exp = expected_bits(s);
            assert (frame_bits[s] === exp) else begin
                data_errors++;
                $display("error %0t ns: led_data[%0d] frame bits expected %h actual %h",
                         $time, s, exp, frame_bits[s]);
            end
        end
        frames_checked++;
    endtask

    // ws2812b decoder, sampled mid cycle
    always @(negedge clk) begin
        logic [led_pkg::STRIPE_COUNT-1:0] level;
        level = led_data;
        if (!check_en) begin
            start_known = 1'b0;
            strips_done = 0;
            for (int s = 0; s < led_pkg::STRIPE_COUNT; s++) begin
                bit_cnt[s]    = 0;
                high_cnt[s]   = 0;
                since_rise[s] = 0;
            end
        end else begin
            for (int s = 0; s < led_pkg::STRIPE_COUNT; s++) begin
                if (level[s] && !prev_level[s]) begin
                    if (bit_cnt[s] != 0) begin
                        // inside a frame, bits back to back
                        assert (since_rise[s] == led_pkg::CYCLES_BIT) else begin
                            timing_errors++;
                            $display("error %0t ns: led_data[%0d] bit period expected %0d actual %0d",
                                     $time, s, led_pkg::CYCLES_BIT, since_rise[s]);
                        end
                    end else if (s == 0) begin
                        // first edge of a frame
                        if (start_known) begin
                            assert (cycle_count - last_start == led_pkg::FRAME_CYCLES) else begin
                                timing_errors++;
                                $display("error %0t ns: led_data frame spacing expected %0d actual %0d",
                                         $time, led_pkg::FRAME_CYCLES, cycle_count - last_start);
                            end
                        end
                        start_known = 1'b1;
                        last_start  = cycle_count;
                    end
                    since_rise[s] = 0;
                    high_cnt[s]   = 0;
                end
                if (level[s]) begin
                    high_cnt[s]++;
                end
                if (!level[s] && prev_level[s]) begin
                    assert (high_cnt[s] == led_pkg::CYCLES_SHORT ||
                            high_cnt[s] == led_pkg::CYCLES_LONG) else begin
                        timing_errors++;
                        $display("error %0t ns: led_data[%0d] high time expected %0d or %0d actual %0d",
                                 $time, s, led_pkg::CYCLES_SHORT, led_pkg::CYCLES_LONG, high_cnt[s]);
                    end
                    // long pulse is a 1
                    shift_bits[s] = {shift_bits[s][FRAME_BITS-2:0],
                                     high_cnt[s] == led_pkg::CYCLES_LONG};
                    bit_cnt[s]++;
                    if (bit_cnt[s] == FRAME_BITS) begin
                        frame_bits[s] = shift_bits[s];
                        bit_cnt[s]    = 0;
                        // short last bits end early, whole frame is in once every strip is done
                        strips_done++;
                        if (strips_done == led_pkg::STRIPE_COUNT) begin
                            strips_done = 0;
                            frames_done++;
                        end
                    end
                end
                since_rise[s]++;
            end
        end
        prev_level = level;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        resetn         = 1'b0;
        spi_clk        = 1'b0;
        spi_mosi       = 1'b0;
        spi_cs_n       = 1'b1;
        check_en       = 1'b0;
        cycle_count    = 0;
        frames_done    = 0;
        timing_errors  = 0;
        data_errors    = 0;
        frames_checked = 0;
        void'($urandom(32'h641e_0d26));
        step_clocks(RESET_CYCLES);
        resetn = 1'b1;

        // full frame, lands while the first refresh runs
        send_frame(led_pkg::FRAME_BYTES, 0);
        wait_frame_gap();
        check_en = 1'b1;
        check_next_frame();
        // same data again one refresh later
        check_next_frame();

        // lone partial byte, memory keeps its contents
        send_frame(0, 5);
        wait_frame_gap();
        check_next_frame();

        // new data from address 0, surplus bytes past the address range and a partial byte dropped
        send_frame(LONG_FRAME_BYTES, 5);
        wait_frame_gap();
        check_next_frame();

        $display("summary: %0d frames compared, %0d timing errors, %0d data errors",
                 frames_checked, timing_errors, data_errors);
        if (timing_errors == 0 && data_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/led_pkg.sv
hw/spi_byte_receiver.sv
hw/frame_ram.sv
hw/bitstream_builder.sv
hw/ws2812b_parallel_out.sv
hw/led_strip_top.sv
verif/tb_led_strip_top.sv
